//--- rpll_params.svh
`ifndef RPLL_PARAMS_SVH
`define RPLL_PARAMS_SVH

// ******************************
// Bus widths
// ******************************
`define RPLL_ADDR_W   8
`define RPLL_DATA_W   32

// ******************************
// Field widths
// ******************************
`define RPLL_CNT_W    8
`define RPLL_REF_W    16
`define RPLL_FB_W     17
`define RPLL_RANGE_W  6
`define RPLL_GAIN_W   5
`define RPLL_FBDIV_W  9

// ******************************
// Register offsets
// ******************************
`define RPLL_ADDR_CTRL         8'h00
`define RPLL_ADDR_TIMING       8'h04
`define RPLL_ADDR_LOCK_DET     8'h08
`define RPLL_ADDR_FASTLOCK_DET 8'h0C
`define RPLL_ADDR_GAIN         8'h10
`define RPLL_ADDR_FBDIV        8'h14
`define RPLL_ADDR_STATUS       8'h18
`define RPLL_ADDR_INT_STATUS   8'h1C

// ******************************
// Register reset values
// ******************************
`define RPLL_CTRL_RST    32'h0000_0000
`define RPLL_TIMING_RST  32'h0000_1008 // Pre-lock 16, bias settle 8.
`define RPLL_LD_RST      32'h0002_0040 // Range 2, window 64.
`define RPLL_GAIN_RST    32'h100C_0604
`define RPLL_FBDIV_RST   32'h0000_0028

`endif

//--- rpll_ctrl_pkg.sv
`include "rpll_params.svh"

package rpll_ctrl_pkg;

  // ******************************
  // Sequencer states
  // ******************************
  typedef enum logic [3:0] {
    IDLE        = 4'd0,
    BIAS_SETTLE = 4'd1,
    PRE_LOCK    = 4'd2,
    FAST_LOCK   = 4'd3,
    LOCKING     = 4'd4,
    LOCKED      = 4'd5
  } rpll_state_e;

  // ******************************
  // Frequency detector
  // ******************************
  typedef struct packed {
    logic [`RPLL_REF_W-1:0]   ref_cycles; // Window length in refclk cycles.
    logic [`RPLL_RANGE_W-1:0] range;      // Allowed count error.
  } rpll_ld_cfg_t;

  typedef struct packed {
    logic                   done;
    logic                   match;
    logic [`RPLL_FB_W-1:0]  fb_cycles;
  } rpll_ld_result_t;

  // Analog PLL controls.
  typedef struct packed {
    logic                     ena;
    logic                     reset;
    logic [`RPLL_GAIN_W-1:0]  int_gain;
    logic [`RPLL_GAIN_W-1:0]  prop_gain;
    logic [`RPLL_FBDIV_W-1:0] fbdiv_sel;
  } rpll_ana_ctrl_t;

endpackage

//--- rpll_reg_pkg.sv
`include "rpll_params.svh"

package rpll_reg_pkg;

  typedef enum logic [`RPLL_ADDR_W-1:0] {
    CTRL         = `RPLL_ADDR_CTRL,
    TIMING       = `RPLL_ADDR_TIMING,
    LOCK_DET     = `RPLL_ADDR_LOCK_DET,
    FASTLOCK_DET = `RPLL_ADDR_FASTLOCK_DET,
    GAIN         = `RPLL_ADDR_GAIN,
    FBDIV        = `RPLL_ADDR_FBDIV,
    STATUS       = `RPLL_ADDR_STATUS,
    INT_STATUS   = `RPLL_ADDR_INT_STATUS
  } rpll_addr_e;

  // ******************************
  // Software configuration
  // ******************************
  typedef struct packed {
    logic                         enable;
    logic                         lock_det_off_after_lock;
    logic                         ready_int_en;
    logic                         loss_int_en;
    logic [`RPLL_CNT_W-1:0]       bias_settle_count;
    logic [`RPLL_CNT_W-1:0]       pre_lock_count;
    rpll_ctrl_pkg::rpll_ld_cfg_t  ld_normal;
    rpll_ctrl_pkg::rpll_ld_cfg_t  ld_fast;
    logic [`RPLL_GAIN_W-1:0]      normal_int_gain;
    logic [`RPLL_GAIN_W-1:0]      normal_prop_gain;
    logic [`RPLL_GAIN_W-1:0]      fl_int_gain;
    logic [`RPLL_GAIN_W-1:0]      fl_prop_gain;
    logic [`RPLL_FBDIV_W-1:0]     fbdiv;
  } rpll_cfg_t;

  typedef struct packed {
    rpll_ctrl_pkg::rpll_state_e   state;
    logic                         locked;
    logic                         ready;
    logic [`RPLL_FB_W-1:0]        fb_cycles;   // Count of the last finished window.
    logic                         lock_gained; // One-cycle pulses.
    logic                         lock_lost;
  } rpll_status_t;

endpackage

//--- rpll_apb_regs.sv
`timescale 1ns/1ps
`include "rpll_params.svh"

module rpll_apb_regs (
  input  logic                        refclk,
  input  logic                        rst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [`RPLL_ADDR_W-1:0]     paddr,
  input  logic [`RPLL_DATA_W-1:0]     pwdata,
  output logic [`RPLL_DATA_W-1:0]     prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  rpll_reg_pkg::rpll_status_t  status,
  output rpll_reg_pkg::rpll_cfg_t     cfg,
  output logic                        core_interrupt
);

  logic       acc;
  logic       wr_acc;
  logic       mapped;
  logic [1:0] int_pend;
  logic [1:0] int_set;
  logic [1:0] int_clr;

  // ******************************
  // Field layout per register
  // ******************************
  function automatic rpll_reg_pkg::rpll_cfg_t put_reg(
    input rpll_reg_pkg::rpll_cfg_t cur,
    input logic [`RPLL_ADDR_W-1:0] addr,
    input logic [`RPLL_DATA_W-1:0] data
  );
    rpll_reg_pkg::rpll_cfg_t nxt;
    nxt = cur;
    case (addr)
      rpll_reg_pkg::CTRL: begin
        nxt.enable                  = data[0];
        nxt.lock_det_off_after_lock = data[1];
        nxt.ready_int_en            = data[2];
        nxt.loss_int_en             = data[3];
      end
      rpll_reg_pkg::TIMING: begin
        nxt.bias_settle_count = data[0 +: `RPLL_CNT_W];
        nxt.pre_lock_count    = data[8 +: `RPLL_CNT_W];
      end
      rpll_reg_pkg::LOCK_DET: begin
        nxt.ld_normal.ref_cycles = data[0 +: `RPLL_REF_W];
        nxt.ld_normal.range      = data[16 +: `RPLL_RANGE_W];
      end
      rpll_reg_pkg::FASTLOCK_DET: begin
        nxt.ld_fast.ref_cycles = data[0 +: `RPLL_REF_W];
        nxt.ld_fast.range      = data[16 +: `RPLL_RANGE_W];
      end
      rpll_reg_pkg::GAIN: begin
        nxt.normal_int_gain  = data[0 +: `RPLL_GAIN_W];
        nxt.normal_prop_gain = data[8 +: `RPLL_GAIN_W];
        nxt.fl_int_gain      = data[16 +: `RPLL_GAIN_W];
        nxt.fl_prop_gain     = data[24 +: `RPLL_GAIN_W];
      end
      rpll_reg_pkg::FBDIV: nxt.fbdiv = data[0 +: `RPLL_FBDIV_W];
      default: nxt = cur;
    endcase
    return nxt;
  endfunction

  function automatic rpll_reg_pkg::rpll_cfg_t cfg_rst();
    rpll_reg_pkg::rpll_cfg_t c;
    c = '0;
    c = put_reg(c, rpll_reg_pkg::CTRL, `RPLL_CTRL_RST);
    c = put_reg(c, rpll_reg_pkg::TIMING, `RPLL_TIMING_RST);
    c = put_reg(c, rpll_reg_pkg::LOCK_DET, `RPLL_LD_RST);
    c = put_reg(c, rpll_reg_pkg::FASTLOCK_DET, `RPLL_LD_RST);
    c = put_reg(c, rpll_reg_pkg::GAIN, `RPLL_GAIN_RST);
    c = put_reg(c, rpll_reg_pkg::FBDIV, `RPLL_FBDIV_RST);
    return c;
  endfunction

  function automatic logic [`RPLL_DATA_W-1:0] get_reg(
    input rpll_reg_pkg::rpll_cfg_t    c,
    input rpll_reg_pkg::rpll_status_t st,
    input logic [1:0]                 pend,
    input logic [`RPLL_ADDR_W-1:0]    addr
  );
    logic [`RPLL_DATA_W-1:0] d;
    d = '0;
    case (addr)
      rpll_reg_pkg::CTRL: begin
        d[3:0] = {c.loss_int_en, c.ready_int_en, c.lock_det_off_after_lock, c.enable};
      end
      rpll_reg_pkg::TIMING: begin
        d[0 +: `RPLL_CNT_W] = c.bias_settle_count;
        d[8 +: `RPLL_CNT_W] = c.pre_lock_count;
      end
      rpll_reg_pkg::LOCK_DET: begin
        d[0 +: `RPLL_REF_W]    = c.ld_normal.ref_cycles;
        d[16 +: `RPLL_RANGE_W] = c.ld_normal.range;
      end
      rpll_reg_pkg::FASTLOCK_DET: begin
        d[0 +: `RPLL_REF_W]    = c.ld_fast.ref_cycles;
        d[16 +: `RPLL_RANGE_W] = c.ld_fast.range;
      end
      rpll_reg_pkg::GAIN: begin
        d[0 +: `RPLL_GAIN_W]  = c.normal_int_gain;
        d[8 +: `RPLL_GAIN_W]  = c.normal_prop_gain;
        d[16 +: `RPLL_GAIN_W] = c.fl_int_gain;
        d[24 +: `RPLL_GAIN_W] = c.fl_prop_gain;
      end
      rpll_reg_pkg::FBDIV: d[0 +: `RPLL_FBDIV_W] = c.fbdiv;
      rpll_reg_pkg::STATUS: begin
        d[3:0]              = st.state;
        d[4]                = st.locked;
        d[5]                = st.ready;
        d[8 +: `RPLL_FB_W]  = st.fb_cycles;
      end
      rpll_reg_pkg::INT_STATUS: d[1:0] = pend;
      default: d = '0;
    endcase
    return d;
  endfunction

  assign acc    = psel & penable;
  assign wr_acc = acc & pwrite;

  always_comb begin
    case (paddr)
      rpll_reg_pkg::CTRL, rpll_reg_pkg::TIMING, rpll_reg_pkg::LOCK_DET,
      rpll_reg_pkg::FASTLOCK_DET, rpll_reg_pkg::GAIN, rpll_reg_pkg::FBDIV,
      rpll_reg_pkg::STATUS, rpll_reg_pkg::INT_STATUS: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign pready  = 1'b1; // No wait states.
  assign pslverr = acc & (~mapped | (pwrite & (paddr == rpll_reg_pkg::STATUS)));
  assign prdata  = (psel & ~pwrite) ? get_reg(cfg, status, int_pend, paddr) : '0;

  always_ff @(posedge refclk) begin
    if (!rst_n) begin
      cfg <= cfg_rst();
    end else if (wr_acc && !pslverr) begin
      cfg <= put_reg(cfg, paddr, pwdata);
    end
  end

  // ******************************
  // Interrupts
  // ******************************
  assign int_set = {status.lock_lost & cfg.loss_int_en, status.lock_gained & cfg.ready_int_en};
  assign int_clr = (wr_acc && (paddr == rpll_reg_pkg::INT_STATUS)) ? pwdata[1:0] : 2'b00;

  always_ff @(posedge refclk) begin
    if (!rst_n) begin
      int_pend <= 2'b00;
    end else begin
      int_pend <= int_set | (int_pend & ~int_clr); // A new event beats the clear.
    end
  end

  assign core_interrupt = |int_pend;

endmodule

//--- rpll_freq_detect.sv
`timescale 1ns/1ps
`include "rpll_params.svh"

module rpll_freq_detect (
  input  logic                            refclk,
  input  logic                            rst_n,
  input  logic                            en,
  input  rpll_ctrl_pkg::rpll_ld_cfg_t     ld_cfg,
  input  logic                            fb_tick,
  output rpll_ctrl_pkg::rpll_ld_result_t  result
);

  rpll_ctrl_pkg::rpll_ld_cfg_t  win_cfg;
  logic                         running;
  logic [`RPLL_REF_W-1:0]       ref_cnt;
  logic [`RPLL_FB_W-1:0]        fb_cnt;
  logic [`RPLL_FB_W-1:0]        fb_total;
  logic [`RPLL_FB_W-1:0]        target;
  logic [`RPLL_FB_W-1:0]        diff;
  logic                         win_last;

  assign fb_total = fb_cnt + {{(`RPLL_FB_W-1){1'b0}}, fb_tick};
  assign target   = {{(`RPLL_FB_W-`RPLL_REF_W){1'b0}}, win_cfg.ref_cycles};
  assign diff     = (fb_total >= target) ? fb_total - target : target - fb_total;
  assign win_last = ({1'b0, ref_cnt} + 1'b1) >= {1'b0, win_cfg.ref_cycles}; // 0 acts as 1.

  always_ff @(posedge refclk) begin
    if (!rst_n) begin
      running <= 1'b0;
      ref_cnt <= '0;
      fb_cnt  <= '0;
      result  <= '0;
    end else if (!en) begin
      running     <= 1'b0;
      ref_cnt     <= '0;
      fb_cnt      <= '0;
      result.done <= 1'b0;
    end else begin
      result.done <= 1'b0;
      if (!running || win_last) begin
        running <= 1'b1;
        ref_cnt <= '0;
        fb_cnt  <= '0;
      end else begin
        ref_cnt <= ref_cnt + 1'b1;
        fb_cnt  <= fb_total;
      end
      if (running && win_last) begin
        result.done      <= 1'b1;
        result.match     <= diff <= {{(`RPLL_FB_W-`RPLL_RANGE_W){1'b0}}, win_cfg.range};
        result.fb_cycles <= fb_total;
      end
    end
  end

  // Settings are taken once per window.
  always_ff @(posedge refclk) begin
    if (en && (!running || win_last)) begin
      win_cfg <= ld_cfg;
    end
  end

endmodule

//--- rpll_lock_seq.sv
`timescale 1ns/1ps
`include "rpll_params.svh"

module rpll_lock_seq (
  input  logic                            refclk,
  input  logic                            rst_n,
  input  rpll_reg_pkg::rpll_cfg_t         cfg,
  input  rpll_ctrl_pkg::rpll_ld_result_t  result,
  output logic                            ld_en,
  output rpll_ctrl_pkg::rpll_ld_cfg_t     ld_cfg,
  output rpll_ctrl_pkg::rpll_ana_ctrl_t   ana,
  output rpll_reg_pkg::rpll_status_t      status
);

  rpll_ctrl_pkg::rpll_state_e state;
  rpll_ctrl_pkg::rpll_state_e state_nxt;
  logic [`RPLL_CNT_W-1:0]     cnt;
  logic [`RPLL_CNT_W-1:0]     settle_target;
  logic                       settle_done;
  logic                       fast_sel;
  logic                       lock_gained;
  logic                       lock_lost;

  assign settle_target = (state == rpll_ctrl_pkg::BIAS_SETTLE) ? cfg.bias_settle_count
                                                               : cfg.pre_lock_count;
  assign settle_done   = ({1'b0, cnt} + 1'b1) >= {1'b0, settle_target};

  // ******************************
  // State machine
  // ******************************
  always_comb begin
    state_nxt = state;
    case (state)
      rpll_ctrl_pkg::IDLE: begin
        state_nxt = rpll_ctrl_pkg::BIAS_SETTLE;
      end
      rpll_ctrl_pkg::BIAS_SETTLE: begin
        if (settle_done) state_nxt = rpll_ctrl_pkg::PRE_LOCK;
      end
      rpll_ctrl_pkg::PRE_LOCK: begin
        if (settle_done) state_nxt = rpll_ctrl_pkg::FAST_LOCK;
      end
      rpll_ctrl_pkg::FAST_LOCK: begin
        if (result.done && result.match) state_nxt = rpll_ctrl_pkg::LOCKING;
      end
      rpll_ctrl_pkg::LOCKING: begin
        if (result.done) begin
          state_nxt = result.match ? rpll_ctrl_pkg::LOCKED : rpll_ctrl_pkg::FAST_LOCK;
        end
      end
      rpll_ctrl_pkg::LOCKED: begin
        if (result.done && !result.match) state_nxt = rpll_ctrl_pkg::FAST_LOCK;
      end
      default: state_nxt = rpll_ctrl_pkg::IDLE;
    endcase
    if (!cfg.enable) state_nxt = rpll_ctrl_pkg::IDLE; // Disable wins from any state.
  end

  always_ff @(posedge refclk) begin
    if (!rst_n) begin
      state       <= rpll_ctrl_pkg::IDLE;
      cnt         <= '0;
      lock_gained <= 1'b0;
      lock_lost   <= 1'b0;
    end else begin
      state       <= state_nxt;
      cnt         <= (state_nxt == state) ? cnt + 1'b1 : '0;
      lock_gained <= (state == rpll_ctrl_pkg::LOCKING) && (state_nxt == rpll_ctrl_pkg::LOCKED);
      lock_lost   <= (state == rpll_ctrl_pkg::LOCKED) && (state_nxt == rpll_ctrl_pkg::FAST_LOCK);
    end
  end

  // ******************************
  // Outputs
  // ******************************
  assign fast_sel = (state != rpll_ctrl_pkg::LOCKING) && (state != rpll_ctrl_pkg::LOCKED);
  assign ld_cfg   = fast_sel ? cfg.ld_fast : cfg.ld_normal;
  assign ld_en    = (state == rpll_ctrl_pkg::FAST_LOCK) || (state == rpll_ctrl_pkg::LOCKING) ||
                    ((state == rpll_ctrl_pkg::LOCKED) && !cfg.lock_det_off_after_lock);

  always_comb begin
    ana.ena       = (state != rpll_ctrl_pkg::IDLE);
    ana.reset     = (state == rpll_ctrl_pkg::IDLE) || (state == rpll_ctrl_pkg::BIAS_SETTLE);
    ana.int_gain  = fast_sel ? cfg.fl_int_gain : cfg.normal_int_gain;
    ana.prop_gain = fast_sel ? cfg.fl_prop_gain : cfg.normal_prop_gain;
    ana.fbdiv_sel = cfg.fbdiv; // Integer divider only.
  end

  always_comb begin
    status.state       = state;
    status.locked      = result.match;
    status.ready       = (state == rpll_ctrl_pkg::LOCKED);
    status.fb_cycles   = result.fb_cycles;
    status.lock_gained = lock_gained;
    status.lock_lost   = lock_lost;
  end

endmodule

//--- rpll_dig_top.sv
`timescale 1ns/1ps
`include "rpll_params.svh"

module rpll_dig_top (
  input  logic                      refclk,
  input  logic                      rst_n,
  input  logic                      apb_psel,
  input  logic                      apb_penable,
  input  logic                      apb_pwrite,
  input  logic [`RPLL_ADDR_W-1:0]   apb_paddr,
  input  logic [`RPLL_DATA_W-1:0]   apb_pwdata,
  output logic [`RPLL_DATA_W-1:0]   apb_prdata,
  output logic                      apb_pready,
  output logic                      apb_pslverr,
  input  logic                      fb_tick,      // One-cycle strobe per feedback edge.
  output logic                      core_ready,
  output logic                      core_interrupt,
  output logic                      rpll_ena,
  output logic                      rpll_reset,
  output logic [`RPLL_GAIN_W-1:0]   rpll_int_ctrl,
  output logic [`RPLL_GAIN_W-1:0]   rpll_prop_ctrl,
  output logic [`RPLL_FBDIV_W-1:0]  rpll_fbdiv_sel
);

  rpll_reg_pkg::rpll_cfg_t          cfg;
  rpll_reg_pkg::rpll_status_t       status;
  rpll_ctrl_pkg::rpll_ld_cfg_t      ld_cfg;
  rpll_ctrl_pkg::rpll_ld_result_t   ld_result;
  rpll_ctrl_pkg::rpll_ana_ctrl_t    ana;
  logic                             ld_en;

  rpll_apb_regs u_rpll_apb_regs (
    .refclk         ( refclk          ),
    .rst_n          ( rst_n           ),
    .psel           ( apb_psel        ),
    .penable        ( apb_penable     ),
    .pwrite         ( apb_pwrite      ),
    .paddr          ( apb_paddr       ),
    .pwdata         ( apb_pwdata      ),
    .prdata         ( apb_prdata      ),
    .pready         ( apb_pready      ),
    .pslverr        ( apb_pslverr     ),
    .status         ( status          ),
    .cfg            ( cfg             ),
    .core_interrupt ( core_interrupt  ));

  rpll_lock_seq u_rpll_lock_seq (
    .refclk  ( refclk     ),
    .rst_n   ( rst_n      ),
    .cfg     ( cfg        ),
    .result  ( ld_result  ),
    .ld_en   ( ld_en      ),
    .ld_cfg  ( ld_cfg     ),
    .ana     ( ana        ),
    .status  ( status     ));

  rpll_freq_detect u_rpll_freq_detect (
    .refclk  ( refclk     ),
    .rst_n   ( rst_n      ),
    .en      ( ld_en      ),
    .ld_cfg  ( ld_cfg     ),
    .fb_tick ( fb_tick    ),
    .result  ( ld_result  ));

  assign core_ready     = status.ready;
  assign rpll_ena       = ana.ena;
  assign rpll_reset     = ana.reset;
  assign rpll_int_ctrl  = ana.int_gain;
  assign rpll_prop_ctrl = ana.prop_gain;
  assign rpll_fbdiv_sel = ana.fbdiv_sel;

endmodule

//--- rpll_dig_tb.sv
`timescale 1ns/1ps
`include "rpll_params.svh"

module rpll_dig_tb;

  localparam int PERIOD = 40;

  typedef enum logic [3:0] {
    WRITE_REG,   // exp is the expected pslverr.
    READ_REG,    // data is the expected pslverr, exp the read data.
    RAND_REG,    // data is the field mask.
    SET_FB,
    START_SEQ,   // data goes to CTRL, exp is the bias settle count.
    WAIT_READY,
    WAIT_LOSS,
    IDLE_CYCLES,
    CHECK_OUTS   // exp holds {core_interrupt, core_ready, rpll_reset, rpll_ena}.
  } step_kind_e;

  typedef struct packed {
    step_kind_e  kind;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  logic                     refclk;
  logic                     rst_n;
  logic                     apb_psel;
  logic                     apb_penable;
  logic                     apb_pwrite;
  logic [`RPLL_ADDR_W-1:0]  apb_paddr;
  logic [`RPLL_DATA_W-1:0]  apb_pwdata;
  logic [`RPLL_DATA_W-1:0]  apb_prdata;
  logic                     apb_pready;
  logic                     apb_pslverr;
  logic                     fb_tick;
  logic                     core_ready;
  logic                     core_interrupt;
  logic                     rpll_ena;
  logic                     rpll_reset;
  logic [`RPLL_GAIN_W-1:0]  rpll_int_ctrl;
  logic [`RPLL_GAIN_W-1:0]  rpll_prop_ctrl;
  logic [`RPLL_FBDIV_W-1:0] rpll_fbdiv_sel;

  step_t       steps[$];
  logic [31:0] lfsr_state = 32'hda0a1e91;
  logic [31:0] gain_word  = `RPLL_GAIN_RST;
  logic [8:0]  fbdiv_exp  = 9'(`RPLL_FBDIV_RST);
  logic        mon_on     = 1'b0;
  int          checks       = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles       = 0;
  int          cycle_limit  = 0;

  rpll_dig_top rpll_dig_top_i (.*);

  always #(PERIOD / 2) refclk = ~refclk;

  // ******************************
  // Helpers
  // ******************************
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERR t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // Taps 32, 22, 2, 1. One step per bit.
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    logic        fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w          = {w[30:0], fb};
    end
    return w;
  endfunction

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge refclk);
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    apb_pwrite  = wr;
    apb_paddr   = addr;
    apb_pwdata  = wdata;
    @(negedge refclk);
    apb_penable = 1'b1;
    #(PERIOD / 4);
    rdata = apb_prdata;
    err   = apb_pslverr;
    check_value("apb_pready", 32'(apb_pready), 32'h1);
    @(posedge refclk);
    #1;
    if (wr && addr == `RPLL_ADDR_FBDIV) fbdiv_exp = wdata[8:0];
    @(negedge refclk);
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
  endtask

  // GAIN holds normal int [4:0], normal prop [12:8], fast int [20:16], fast prop [28:24].
  task automatic check_gains(input logic fast);
    if (fast) begin
      check_value("rpll_int_ctrl", 32'(rpll_int_ctrl), 32'(gain_word[20:16]));
      check_value("rpll_prop_ctrl", 32'(rpll_prop_ctrl), 32'(gain_word[28:24]));
    end else begin
      check_value("rpll_int_ctrl", 32'(rpll_int_ctrl), 32'(gain_word[4:0]));
      check_value("rpll_prop_ctrl", 32'(rpll_prop_ctrl), 32'(gain_word[12:8]));
    end
  endtask

  task automatic add_step(input step_kind_e kind, input logic [7:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
    step_t s;
    s.kind = kind;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  function automatic int step_budget(input step_t s);
    int b;
    case (s.kind)
      WRITE_REG, READ_REG:                 b = 4;
      RAND_REG:                            b = 8;
      START_SEQ:                           b = int'(s.exp) + 10;
      WAIT_READY, WAIT_LOSS, IDLE_CYCLES:  b = int'(s.data) + 2;
      default:                             b = 2;
    endcase
    return b;
  endfunction

  // ******************************
  // Stimulus table
  // ******************************
  task automatic load_table();
    add_step(CHECK_OUTS,  8'h00, 32'h0, 32'h2);
    add_step(READ_REG,    `RPLL_ADDR_CTRL, 32'h0, `RPLL_CTRL_RST);
    add_step(READ_REG,    `RPLL_ADDR_TIMING, 32'h0, `RPLL_TIMING_RST);
    add_step(READ_REG,    `RPLL_ADDR_LOCK_DET, 32'h0, `RPLL_LD_RST);
    add_step(READ_REG,    `RPLL_ADDR_FASTLOCK_DET, 32'h0, `RPLL_LD_RST);
    add_step(READ_REG,    `RPLL_ADDR_GAIN, 32'h0, `RPLL_GAIN_RST);
    add_step(READ_REG,    `RPLL_ADDR_FBDIV, 32'h0, `RPLL_FBDIV_RST);
    add_step(READ_REG,    `RPLL_ADDR_STATUS, 32'h0, 32'h0);
    add_step(READ_REG,    `RPLL_ADDR_INT_STATUS, 32'h0, 32'h0);
    add_step(RAND_REG,    `RPLL_ADDR_GAIN, 32'h1F1F_1F1F, 32'h0);
    add_step(RAND_REG,    `RPLL_ADDR_FBDIV, 32'h0000_01FF, 32'h0);
    add_step(RAND_REG,    `RPLL_ADDR_LOCK_DET, 32'h003F_FFFF, 32'h0);
    add_step(READ_REG,    8'h20, 32'h1, 32'h0);
    add_step(WRITE_REG,   `RPLL_ADDR_STATUS, 32'h5, 32'h1);
    add_step(READ_REG,    `RPLL_ADDR_STATUS, 32'h0, 32'h0);
    add_step(WRITE_REG,   `RPLL_ADDR_LOCK_DET, 32'h0002_0020, 32'h0);     // Window 32, range 2.
    add_step(WRITE_REG,   `RPLL_ADDR_FASTLOCK_DET, 32'h0002_0020, 32'h0);
    add_step(SET_FB,      8'h00, 32'h1, 32'h0);
    add_step(START_SEQ,   8'h00, 32'hD, 32'd8);           // Enable with both interrupts on.
    add_step(WAIT_READY,  8'h00, 32'd200, 32'h0);
    add_step(IDLE_CYCLES, 8'h00, 32'd2, 32'h0);
    add_step(CHECK_OUTS,  8'h00, 32'h0, 32'hD);
    add_step(READ_REG,    `RPLL_ADDR_CTRL, 32'h0, 32'hD);
    add_step(READ_REG,    `RPLL_ADDR_STATUS, 32'h0, 32'h0000_2035); // LOCKED, count 32.
    add_step(READ_REG,    `RPLL_ADDR_INT_STATUS, 32'h0, 32'h1);
    add_step(WRITE_REG,   `RPLL_ADDR_INT_STATUS, 32'h1, 32'h0);
    add_step(CHECK_OUTS,  8'h00, 32'h0, 32'h5);
    add_step(SET_FB,      8'h00, 32'h0, 32'h0);
    add_step(WAIT_LOSS,   8'h00, 32'd64, 32'h0);          // Two windows of 32.
    add_step(IDLE_CYCLES, 8'h00, 32'd2, 32'h0);
    add_step(CHECK_OUTS,  8'h00, 32'h0, 32'h9);
    add_step(READ_REG,    `RPLL_ADDR_INT_STATUS, 32'h0, 32'h2);
    add_step(IDLE_CYCLES, 8'h00, 32'd40, 32'h0);
    add_step(READ_REG,    `RPLL_ADDR_STATUS, 32'h0, 32'h3);
    add_step(WRITE_REG,   `RPLL_ADDR_INT_STATUS, 32'h3, 32'h0);
    add_step(CHECK_OUTS,  8'h00, 32'h0, 32'h1);
    add_step(WRITE_REG,   `RPLL_ADDR_CTRL, 32'h0, 32'h0);
    add_step(IDLE_CYCLES, 8'h00, 32'd2, 32'h0);
    add_step(CHECK_OUTS,  8'h00, 32'h0, 32'h2);
    add_step(READ_REG,    `RPLL_ADDR_STATUS, 32'h0, 32'h0);
    add_step(READ_REG,    `RPLL_ADDR_INT_STATUS, 32'h0, 32'h0);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] rd;
    logic [31:0] w;
    logic        err;
    int          n;
    case (s.kind)
      WRITE_REG: begin
        apb_access(1'b1, s.addr, s.data, rd, err);
        check_value("pslverr", 32'(err), s.exp);
      end
      READ_REG: begin
        apb_access(1'b0, s.addr, '0, rd, err);
        check_value("pslverr", 32'(err), s.data);
        check_value($sformatf("prdata[0x%02h]", s.addr), rd, s.exp);
      end
      RAND_REG: begin
        w = rand_word();
        apb_access(1'b1, s.addr, w, rd, err);
        check_value("pslverr", 32'(err), 32'h0);
        apb_access(1'b0, s.addr, '0, rd, err);
        check_value($sformatf("prdata[0x%02h]", s.addr), rd, w & s.data);
        if (s.addr == `RPLL_ADDR_GAIN) gain_word = w & s.data;
      end
      SET_FB: begin
        @(negedge refclk);
        fb_tick = s.data[0]; // Held level, so every window counts all or nothing.
      end
      START_SEQ: begin
        apb_access(1'b1, `RPLL_ADDR_CTRL, s.data, rd, err);
        check_value("rpll_ena", 32'(rpll_ena), 32'h0);
        @(negedge refclk);
        check_value("rpll_ena", 32'(rpll_ena), 32'h1);
        n = 0;
        while (rpll_reset && n < 256) begin
          check_gains(1'b1);
          @(negedge refclk);
          n++;
        end
        check_value("rpll_reset delay", 32'(n), s.exp);
      end
      WAIT_READY, WAIT_LOSS: begin
        n = 0;
        while ((core_ready == (s.kind == WAIT_LOSS)) && n < int'(s.data)) begin
          @(negedge refclk);
          n++;
        end
        if (core_ready == (s.kind == WAIT_LOSS)) begin
          $display("core_ready did not change within %0d cycles", s.data);
          other_errors++;
        end else if (s.kind == WAIT_READY) begin
          check_gains(1'b0);
        end
      end
      IDLE_CYCLES: repeat (s.data) @(negedge refclk);
      CHECK_OUTS: begin
        check_value("{core_interrupt,core_ready,rpll_reset,rpll_ena}",
                    32'({core_interrupt, core_ready, rpll_reset, rpll_ena}), s.exp);
      end
      default: begin
        $display("Unknown step kind in the stimulus table");
        other_errors++;
      end
    endcase
  endtask

  // The divider output follows FBDIV in every cycle.
  always @(negedge refclk) begin
    if (mon_on) check_value("rpll_fbdiv_sel", 32'(rpll_fbdiv_sel), 32'(fbdiv_exp));
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge refclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Done: errors found");
    $finish;
  end

  // ******************************
  // Main sequence
  // ******************************
  initial begin
    int total;
    refclk      = 1'b0;
    rst_n       = 1'b0;
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
    apb_pwrite  = 1'b0;
    apb_paddr   = '0;
    apb_pwdata  = '0;
    fb_tick     = 1'b0;
    load_table();
    total = 0;
    foreach (steps[i]) total += step_budget(steps[i]);
    cycle_limit = total + 60; // Reset and slack.
    repeat (2) @(posedge refclk);
    @(negedge refclk);
    rst_n  = 1'b1;
    mon_on = 1'b1;
    foreach (steps[i]) run_step(steps[i]);
    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- rpll_dig.f
+incdir+.
rpll_ctrl_pkg.sv
rpll_reg_pkg.sv
rpll_apb_regs.sv
rpll_freq_detect.sv
rpll_lock_seq.sv
rpll_dig_top.sv
rpll_dig_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rpll_dig.f --top-module rpll_dig_tb -o rpll_dig_sim
./obj_dir/rpll_dig_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
